// File: files.f
+incdir+src
src/fifo_pkg.sv
src/fifo_push_ctrl_core.sv
src/fifo_pop_ctrl_core.sv
src/fifo_occupancy.sv
src/fifo_ram_1r1w.sv
src/fifo_1r1w.sv
verif/fifo_checker.sv
verif/fifo_tb.sv

// File: Makefile
# Verilator build and run for the FIFO testbench

TOP       ?= fifo_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_LINE := STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: TOP FILELIST BUILD_DIR LOG VERILATOR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_LINE)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/fifo_tb.sv
// Module fifo_tb: clock, reset, stimulus, reference queue, comparator, timeout, status
`timescale 1ns/10ps
`include "fifo_settings.svh"

module fifo_tb;

  localparam int W = `FIFO_WIDTH;
  localparam int AW = `FIFO_ADDR_WIDTH;

  // Beat counts per test, the held word of each capacity test included
  localparam int N_ORDER = 60;
  localparam int N_BYPASS = 10;
  localparam int N_CAP_FULL = `FIFO_DEPTH + 2;
  localparam int N_CAP_SMALL = 6;
  localparam int N_BACKPR = 80;
  localparam int N_WRAP = 30;
  localparam int TOTAL_BEATS = N_ORDER + N_BYPASS + N_CAP_FULL + N_CAP_SMALL
                               + N_BACKPR + N_WRAP;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 20;

  // Pop side drive modes
  localparam logic [1:0] POP_HOLD = 2'd0;
  localparam logic [1:0] POP_OPEN = 2'd1;
  localparam logic [1:0] POP_RAND = 2'd2;

  logic          clk;
  logic          rst_n;
  logic          push_valid;
  logic [W-1:0]  push_data;
  logic          push_ready;
  logic          pop_valid;
  logic [W-1:0]  pop_data;
  logic          pop_ready;
  logic [AW-1:0] addr_base;
  logic [AW-1:0] addr_bound;

  logic [W-1:0]  exp_q[$];
  logic [1:0]    pop_mode = POP_HOLD;
  integer        seed = 32'hb518c59f;
  int            errors = 0;
  int            cycle = 0;

  fifo_1r1w UUT (.*);

  // Words held = window size plus the staging register
  function automatic int expected_capacity(input logic [AW-1:0] base,
                                           input logic [AW-1:0] bound);
    return int'(bound) - int'(base) + 2;
  endfunction

  // --------------------------------------------------
  // Clock, timeout and pop_ready driver
  // --------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    while (cycle < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle++;
    end
    $display("Timeout: run exceeded %0d cycles without finishing", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    pop_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      case (pop_mode)
        POP_OPEN: pop_ready = 1'b1;
        POP_RAND: pop_ready = 1'($random(seed));
        default:  pop_ready = 1'b0;
      endcase
    end
  end

  // --------------------------------------------------
  // Reference queue and comparator
  // --------------------------------------------------
  always @(posedge clk) begin
    if (rst_n && push_valid && push_ready) begin
      exp_q.push_back(push_data);
    end
  end

  always @(posedge clk) begin
    logic [W-1:0] expected;
    if (rst_n && pop_valid && pop_ready) begin
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("Pop beat with no word left in the reference queue");
      end
      if (exp_q.size() != 0) begin
        expected = exp_q.pop_front();
        assert (pop_data == expected) else begin
          errors++;
          $display("ERR pop_data expected %h actual %h", expected, pop_data);
        end
      end
    end
  end

  // --------------------------------------------------
  // Stimulus tasks, all entered 1 ns after a rising edge
  // --------------------------------------------------
  task automatic apply_reset(input logic [AW-1:0] base, input logic [AW-1:0] bound);
    pop_mode = POP_HOLD;
    rst_n = 1'b0;
    push_valid = 1'b0;
    addr_base = base;
    addr_bound = bound;
    exp_q.delete();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // Offer one word and hold it until accepted
  task automatic push_word(input logic [W-1:0] data);
    push_valid = 1'b1;
    push_data = data;
    do @(posedge clk); while (!push_ready);
    #1;
    push_valid = 1'b0;
  endtask

  task automatic push_stream(input int n, input bit with_gaps);
    for (int i = 0; i < n; i++) begin
      if (with_gaps && (($random(seed) & 3) == 0)) begin
        push_valid = 1'b0;
        @(posedge clk);
        #1;
      end
      push_word(W'($random(seed)));
    end
  endtask

  // Open the pop side until every pushed word is out
  task automatic drain_fifo();
    pop_mode = POP_OPEN;
    push_valid = 1'b0;
    while (exp_q.size() != 0 || pop_valid) begin
      @(posedge clk);
      #1;
    end
    // A stray RAM word needs a read issue and a read cycle to surface
    repeat (4) begin
      @(posedge clk);
      #1;
    end
    assert (!pop_valid && exp_q.size() == 0) else begin
      errors++;
      $display("Drain failed, FIFO still shows data after the reference queue emptied");
    end
  endtask

  // Fill with pop side stalled, count beats until push_ready falls
  task automatic check_capacity(input logic [AW-1:0] base, input logic [AW-1:0] bound);
    int accepted;
    bit filling;
    accepted = 0;
    filling = 1'b1;
    apply_reset(base, bound);
    push_valid = 1'b1;
    push_data = W'($random(seed));
    while (filling) begin
      @(posedge clk);
      if (push_ready) begin
        accepted++;
        #1;
        push_data = W'($random(seed));
      end else begin
        filling = 1'b0;
      end
    end
    #1;
    assert (accepted == expected_capacity(base, bound)) else begin
      errors++;
      $display("ERR accepted_beats expected %h actual %h",
               expected_capacity(base, bound), accepted);
    end
    // Refused word stays offered until the pop side frees room
    pop_mode = POP_OPEN;
    do @(posedge clk); while (!push_ready);
    #1;
    push_valid = 1'b0;
    drain_fifo();
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    rst_n = 1'b0;
    push_valid = 1'b0;
    push_data = '0;
    addr_base = '0;
    addr_bound = AW'(`FIFO_DEPTH - 1);

    // Order and data with pop side always open
    apply_reset('0, AW'(`FIFO_DEPTH - 1));
    pop_mode = POP_OPEN;
    @(posedge clk);
    #1;
    push_stream(N_ORDER, 1'b0);
    drain_fifo();

    // Bypass, one word at a time into an empty FIFO
    for (int i = 0; i < N_BYPASS; i++) begin
      push_word(W'($random(seed)));
      assert (pop_valid) else begin
        errors++;
        $display("Bypass word %0d missing from pop_valid one cycle after its push", i);
      end
      repeat (3) begin
        @(posedge clk);
        #1;
      end
      assert (exp_q.size() == 0) else begin
        errors++;
        $display("Bypass word %0d not popped before the next push", i);
      end
    end

    // Capacity for the whole RAM and for a narrow window
    check_capacity('0, AW'(`FIFO_DEPTH - 1));
    check_capacity(AW'(2), AW'(5));

    // Back-pressure with random gaps on both sides
    apply_reset('0, AW'(`FIFO_DEPTH - 1));
    pop_mode = POP_RAND;
    push_stream(N_BACKPR, 1'b1);
    drain_fifo();

    // Narrow window streaming, addresses wrap many times
    apply_reset(AW'(2), AW'(5));
    pop_mode = POP_RAND;
    push_stream(N_WRAP, 1'b0);
    drain_fifo();

    $display("Run complete: %0d check errors, %0d assertion failures",
             errors, UUT.u_checker.fail_count);
    if (errors == 0 && UUT.u_checker.fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: verif/fifo_checker.sv
// Module fifo_checker with bound handshake and address assertions, plus its bind to fifo_1r1w
`timescale 1ns/10ps
`include "fifo_settings.svh"

module fifo_checker (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        push_ready,
  input logic                        bypass_valid,
  input logic                        bypass_ready,
  input logic                        pop_valid,
  input logic                        pop_ready,
  input logic [`FIFO_WIDTH-1:0]      pop_data,
  input logic [`FIFO_ADDR_WIDTH-1:0] ram_wr_addr,
  input logic [`FIFO_ADDR_WIDTH-1:0] addr_base,
  input logic [`FIFO_ADDR_WIDTH-1:0] addr_bound
);

  // Number of failed assertions, read by the testbench at the end
  int unsigned fail_count = 0;

  // --------------------------------------------------
  // Pop side holds its word under back-pressure
  // --------------------------------------------------
  pop_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data))
    else begin
      fail_count++;
      $error("pop_valid or pop_data changed while pop_ready was low");
    end

  // --------------------------------------------------
  // Push side, a refused word is not taken
  // --------------------------------------------------
  // Bypass steering ignores push_ready, so full must keep bypass_ready low
  push_refused_a: assert property (@(posedge clk) disable iff (!rst_n)
    !push_ready |-> !(bypass_valid && bypass_ready))
    else begin
      fail_count++;
      $error("word taken through the bypass while push_ready was low");
    end

  // Write pointer never leaves the configured window
  wr_addr_window_a: assert property (@(posedge clk) disable iff (!rst_n)
    ram_wr_addr >= addr_base && ram_wr_addr <= addr_bound)
    else begin
      fail_count++;
      $error("RAM write address outside the address window");
    end

  // Staging register comes out of reset empty
  pop_reset_a: assert property (@(posedge clk) $rose(rst_n) |-> !pop_valid)
    else begin
      fail_count++;
      $error("pop_valid high in the first cycle after reset");
    end

endmodule

bind fifo_1r1w fifo_checker u_checker (.*);

// File: src/fifo_1r1w.sv
// Module fifo_1r1w: FIFO top joining push core, RAM, occupancy and pop core
`timescale 1ns/10ps
`include "fifo_settings.svh"

module fifo_1r1w (
  input  logic                        clk,
  input  logic                        rst_n,
  // Push side
  input  logic                        push_valid,
  input  logic [`FIFO_WIDTH-1:0]      push_data,
  output logic                        push_ready,
  // Pop side
  output logic                        pop_valid,
  output logic [`FIFO_WIDTH-1:0]      pop_data,
  input  logic                        pop_ready,
  // Static address window, base at most bound
  input  logic [`FIFO_ADDR_WIDTH-1:0] addr_base,
  input  logic [`FIFO_ADDR_WIDTH-1:0] addr_bound
);

  // --------------------------------------------------
  // Internal nets
  // --------------------------------------------------

  logic                        full;
  logic                        ram_empty;
  logic                        bypass_valid;
  logic                        bypass_ready;
  logic [`FIFO_WIDTH-1:0]      bypass_data;
  logic                        ram_wr_valid;
  logic [`FIFO_ADDR_WIDTH-1:0] ram_wr_addr;
  logic [`FIFO_WIDTH-1:0]      ram_wr_data;
  logic                        ram_rd_valid;
  logic [`FIFO_ADDR_WIDTH-1:0] ram_rd_addr;
  logic [`FIFO_WIDTH-1:0]      ram_rd_data;

  // --------------------------------------------------
  // Blocks
  // --------------------------------------------------

  fifo_push_ctrl_core u_push_ctrl (
    .clk, .rst_n, .push_valid, .push_data, .push_ready, .full,
    .bypass_ready, .bypass_valid, .bypass_data,
    .ram_wr_valid, .ram_wr_addr, .ram_wr_data, .addr_base, .addr_bound
  );

  fifo_ram_1r1w u_ram (
    .clk, .wr_valid(ram_wr_valid), .wr_addr(ram_wr_addr), .wr_data(ram_wr_data),
    .rd_valid(ram_rd_valid), .rd_addr(ram_rd_addr), .rd_data(ram_rd_data)
  );

  fifo_occupancy u_occupancy (
    .clk, .rst_n, .ram_wr_valid, .ram_rd_valid, .addr_base, .addr_bound,
    .full, .ram_empty
  );

  fifo_pop_ctrl_core u_pop_ctrl (
    .clk, .rst_n, .ram_empty, .ram_rd_valid, .ram_rd_addr, .ram_rd_data,
    .bypass_valid, .bypass_data, .bypass_ready,
    .pop_valid, .pop_data, .pop_ready, .addr_base, .addr_bound
  );

endmodule

// File: src/fifo_ram_1r1w.sv
// Module fifo_ram_1r1w: flop array, one write port, one registered read port
`timescale 1ns/10ps
`include "fifo_settings.svh"

module fifo_ram_1r1w (
  input  logic                        clk,
  // Write port
  input  logic                        wr_valid,
  input  logic [`FIFO_ADDR_WIDTH-1:0] wr_addr,
  input  logic [`FIFO_WIDTH-1:0]      wr_data,
  // Read port, data one cycle after rd_valid
  input  logic                        rd_valid,
  input  logic [`FIFO_ADDR_WIDTH-1:0] rd_addr,
  output logic [`FIFO_WIDTH-1:0]      rd_data
);

  // Storage array
  logic [`FIFO_WIDTH-1:0] mem [`FIFO_DEPTH];

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // --------------------------------------------------
  // Read port
  // --------------------------------------------------

  // Output register holds its word between reads
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: src/fifo_occupancy.sv
// Module fifo_occupancy: RAM word counter driving full and ram_empty
`timescale 1ns/10ps
`include "fifo_settings.svh"

module fifo_occupancy import fifo_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  // Write from push core, read issue from pop core
  input  logic                        ram_wr_valid,
  input  logic                        ram_rd_valid,
  // Static address window
  input  logic [`FIFO_ADDR_WIDTH-1:0] addr_base,
  input  logic [`FIFO_ADDR_WIDTH-1:0] addr_bound,
  // Status
  output logic                        full,
  output logic                        ram_empty
);

  // One bit wider than the address, can reach the whole depth
  logic [`FIFO_ADDR_WIDTH:0] count;

  // --------------------------------------------------
  // Word count
  // --------------------------------------------------

  // Write and read in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (ram_wr_valid && !ram_rd_valid) begin
      count <= count + (`FIFO_ADDR_WIDTH+1)'(1);
    end else if (!ram_wr_valid && ram_rd_valid) begin
      count <= count - (`FIFO_ADDR_WIDTH+1)'(1);
    end
  end

  // --------------------------------------------------
  // Status flags
  // --------------------------------------------------

  // Full means every word of the window is taken
  assign full      = (count == window_size(addr_base, addr_bound));
  assign ram_empty = (count == '0);

endmodule

// File: src/fifo_pop_ctrl_core.sv
// Module fifo_pop_ctrl_core: RAM read issue, read address, staging register, bypass accept
`timescale 1ns/10ps
`include "fifo_settings.svh"

module fifo_pop_ctrl_core import fifo_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  // From occupancy tracker
  input  logic                        ram_empty,
  // RAM read port
  output logic                        ram_rd_valid,
  output logic [`FIFO_ADDR_WIDTH-1:0] ram_rd_addr,
  input  logic [`FIFO_WIDTH-1:0]      ram_rd_data,
  // Bypass from the push core
  input  logic                        bypass_valid,
  input  logic [`FIFO_WIDTH-1:0]      bypass_data,
  output logic                        bypass_ready,
  // Pop side
  output logic                        pop_valid,
  output logic [`FIFO_WIDTH-1:0]      pop_data,
  input  logic                        pop_ready,
  // Static address window
  input  logic [`FIFO_ADDR_WIDTH-1:0] addr_base,
  input  logic [`FIFO_ADDR_WIDTH-1:0] addr_bound
);

  logic [`FIFO_ADDR_WIDTH-1:0] rd_addr;
  logic                        rd_inflight;
  logic                        pop_beat;
  logic                        slot_free;
  logic                        rd_issue;
  logic                        bypass_beat;

  // --------------------------------------------------
  // Handshake decode
  // --------------------------------------------------

  assign pop_beat = pop_valid && pop_ready;

  // Staging can take a new word next cycle
  // Nothing in flight, and staging empty or leaving now
  assign slot_free = !rd_inflight && (!pop_valid || pop_ready);

  // Read a RAM word whenever there is one and room for it
  assign rd_issue = !ram_empty && slot_free;

  // Bypass only with RAM drained, keeps words in order
  assign bypass_ready = ram_empty && slot_free;
  assign bypass_beat  = bypass_valid && bypass_ready;

  assign ram_rd_valid = rd_issue;
  assign ram_rd_addr  = rd_addr;

  // --------------------------------------------------
  // Read address and in-flight tracking
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_addr     <= addr_base;
      rd_inflight <= 1'b0;
    end else begin
      // RAM data shows up one cycle after issue
      rd_inflight <= rd_issue;
      if (rd_issue) begin
        rd_addr <= addr_advance(rd_addr, addr_base, addr_bound);
      end
    end
  end

  // --------------------------------------------------
  // Output staging register
  // --------------------------------------------------

  // Returning read and bypass never overlap, both need no read in flight
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pop_valid <= 1'b0;
    end else if (rd_inflight || bypass_beat) begin
      pop_valid <= 1'b1;
    end else if (pop_beat) begin
      pop_valid <= 1'b0;
    end
  end

  // Payload only, valid bit above qualifies it
  always_ff @(posedge clk) begin
    if (rd_inflight) begin
      pop_data <= ram_rd_data;
    end else if (bypass_beat) begin
      pop_data <= bypass_data;
    end
  end

endmodule

// File: src/fifo_push_ctrl_core.sv
// Module fifo_push_ctrl_core: push flow control, bypass steering, RAM write address
`timescale 1ns/10ps
`include "fifo_settings.svh"

module fifo_push_ctrl_core import fifo_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  // Push side
  input  logic                        push_valid,
  input  logic [`FIFO_WIDTH-1:0]      push_data,
  output logic                        push_ready,
  // From occupancy tracker
  input  logic                        full,
  // Bypass toward the pop core
  input  logic                        bypass_ready,
  output logic                        bypass_valid,
  output logic [`FIFO_WIDTH-1:0]      bypass_data,
  // RAM write port
  output logic                        ram_wr_valid,
  output logic [`FIFO_ADDR_WIDTH-1:0] ram_wr_addr,
  output logic [`FIFO_WIDTH-1:0]      ram_wr_data,
  // Static address window
  input  logic [`FIFO_ADDR_WIDTH-1:0] addr_base,
  input  logic [`FIFO_ADDR_WIDTH-1:0] addr_bound
);

  logic push_beat;

  // --------------------------------------------------
  // Flow control
  // --------------------------------------------------

  // Ready straight from full, no register in between
  assign push_ready = !full;
  assign push_beat  = push_valid && push_ready;

  // --------------------------------------------------
  // Steering between bypass and RAM
  // --------------------------------------------------

  // Offer every word to the pop side when bypass is built in
  // The pop core only takes it while RAM and staging are drained
  assign bypass_valid = push_valid && (`FIFO_ENABLE_BYPASS != 0);
  assign bypass_data  = push_data;

  // Word lands in RAM unless the pop side took it this cycle
  assign ram_wr_valid = push_beat && ((`FIFO_ENABLE_BYPASS == 0) || !bypass_ready);
  assign ram_wr_data  = push_data;

  // --------------------------------------------------
  // Write address counter
  // --------------------------------------------------

  // Walks the window from base to bound, then wraps
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ram_wr_addr <= addr_base;
    end else if (ram_wr_valid) begin
      ram_wr_addr <= addr_advance(ram_wr_addr, addr_base, addr_bound);
    end
  end

endmodule

// File: src/fifo_pkg.sv
// Package fifo_pkg with the address-window functions addr_advance and window_size
`include "fifo_settings.svh"

package fifo_pkg;

  // Next address inside the window [base, bound]
  // Wraps back to base once bound has been used
  function automatic logic [`FIFO_ADDR_WIDTH-1:0] addr_advance(
    input logic [`FIFO_ADDR_WIDTH-1:0] addr,
    input logic [`FIFO_ADDR_WIDTH-1:0] base,
    input logic [`FIFO_ADDR_WIDTH-1:0] bound
  );
    return (addr == bound) ? base : addr + `FIFO_ADDR_WIDTH'(1);
  endfunction

  // RAM words covered by the window, bound is inclusive
  // One extra bit so a window over the whole RAM still fits
  function automatic logic [`FIFO_ADDR_WIDTH:0] window_size(
    input logic [`FIFO_ADDR_WIDTH-1:0] base,
    input logic [`FIFO_ADDR_WIDTH-1:0] bound
  );
    return ({1'b0, bound} - {1'b0, base}) + (`FIFO_ADDR_WIDTH+1)'(1);
  endfunction

endpackage

// File: src/fifo_settings.svh
// FIFO depth, data width, address width and bypass enable macros
`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// --------------------------------------------------
// Storage geometry
// --------------------------------------------------

// Number of RAM entries; the address window may use fewer
`define FIFO_DEPTH 8

// Data word width in bits
`define FIFO_WIDTH 16

// Ceiling log2 of the depth, never below 1
`define FIFO_ADDR_WIDTH 3

// --------------------------------------------------
// Datapath options
// --------------------------------------------------

// 1 lets an empty FIFO hand words straight to the pop side
`define FIFO_ENABLE_BYPASS 1

`endif
